// File: Makefile
# Verilator build and run of the prefix adder testbench
# any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR  ?= verilator
TOP        ?= prefixAdderTb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
BASE_FLAGS ?= --binary --assert --timing -j 0
VFLAGS     ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG), check the log"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(BASE_FLAGS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

# the run status is ignored here, the log decides
test: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "result: FAIL, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
		echo "result: FAIL, the run ended without a verdict"; \
		exit 1; \
	else \
		echo "result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/adderPkg.sv
package adderPkg;

    localparam int dataWidth = 32;
    localparam int treeLevels = $clog2(dataWidth);
    // internal nodes of a full binary tree over the operand bits
    localparam int treeNodes = dataWidth - 1;

    typedef logic [dataWidth-1:0] dataWord;

    // bitwise generate and propagate
    typedef struct packed {
        dataWord gen;
        dataWord prop;
    } pgVector;

    // group terms of levels 1 to treeLevels, level 1 in the low bits
    typedef struct packed {
        logic [treeNodes-1:0] gen;
        logic [treeNodes-1:0] prop;
    } sweepTree;

    // first node of a level inside sweepTree
    // level 0 lands on -dataWidth, so {tree, leaves} indexes with one formula
    function automatic int levelOffset(input int level);
        return dataWidth - 2 * (dataWidth >> level);
    endfunction

endpackage

// File: source/opPkg.sv
package opPkg;

    typedef enum logic [1:0] {
        add           = 2'b00,
        sub           = 2'b01,
        subWithBorrow = 2'b10
    } aluOp;

    typedef struct packed {
        aluOp              opcode;
        adderPkg::dataWord a;
        adderPkg::dataWord b;
        logic              carryIn;
    } addRequest;

    // carryIn here is the effective one, after the opcode is applied
    typedef struct packed {
        logic              valid;
        adderPkg::dataWord a;
        adderPkg::pgVector pg;
        logic              carryIn;
    } pgPacket;

    typedef struct packed {
        logic               valid;
        logic               aSign;
        logic               bSign;
        adderPkg::pgVector  pg;
        logic               carryIn;
        adderPkg::sweepTree tree;
    } treePacket;

    typedef struct packed {
        logic              valid;
        logic              aSign;
        logic              bSign;
        adderPkg::dataWord prop;
        adderPkg::dataWord carries;
        logic              carryOut;
    } carryPacket;

    typedef struct packed {
        adderPkg::dataWord sum;
        logic              carryOut;
        logic              overflow;
        logic              zero;
    } addResult;

endpackage

// File: source/operandStage.sv
module operandStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  opPkg::addRequest request,
    output opPkg::pgPacket   pgOut
);

    adderPkg::dataWord bCond;
    logic              carryEff;

    logic              validQ;
    adderPkg::dataWord aQ;
    adderPkg::pgVector pgQ;
    logic              carryQ;

    // subtraction works as a + ~b + carry
    always_comb begin
        case (request.opcode)
            opPkg::sub: begin
                bCond    = ~request.b;
                carryEff = 1'b1;
            end
            opPkg::subWithBorrow: begin
                bCond    = ~request.b;
                carryEff = request.carryIn;
            end
            default: begin
                bCond    = request.b;
                carryEff = request.carryIn;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        aQ       <= request.a;
        pgQ.gen  <= request.a & bCond;
        pgQ.prop <= request.a ^ bCond;
        carryQ   <= carryEff;
    end

    assign pgOut = '{valid: validQ, a: aQ, pg: pgQ, carryIn: carryQ};

endmodule

// File: source/prefixAdderTop.sv
module prefixAdderTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  opPkg::addRequest request,
    output logic             outValid,
    output opPkg::addResult  result
);

    // stage to stage packets with their own valid bits
    opPkg::pgPacket    pgBus;
    opPkg::treePacket  treeBus;
    opPkg::carryPacket carryBus;

    operandStage uOperand (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .request (request),
        .pgOut   (pgBus)
    );

    prefixUpSweep uUpSweep (
        .clk     (clk),
        .rstN    (rstN),
        .pgIn    (pgBus),
        .treeOut (treeBus)
    );

    prefixDownSweep uDownSweep (
        .clk      (clk),
        .rstN     (rstN),
        .treeIn   (treeBus),
        .carryOut (carryBus)
    );

    sumStage uSum (
        .clk      (clk),
        .rstN     (rstN),
        .carryIn  (carryBus),
        .outValid (outValid),
        .result   (result)
    );

endmodule

// File: source/prefixDownSweep.sv
module prefixDownSweep (
    input  logic              clk,
    input  logic              rstN,
    input  opPkg::treePacket  treeIn,
    output opPkg::carryPacket carryOut
);

    localparam int width = adderPkg::dataWidth;
    localparam int allNodes = adderPkg::treeNodes + width;

    // leaves in the low bits, then levels 1 and up
    logic [allNodes-1:0] allGen;
    logic [allNodes-1:0] allProp;
    // group generate over bits [pos:0]
    adderPkg::dataWord   prefixGen;

    logic              validQ;
    logic              aSignQ;
    logic              bSignQ;
    adderPkg::dataWord propQ;
    adderPkg::dataWord carriesQ;
    logic              carryOutQ;

    assign allGen  = {treeIn.tree.gen, treeIn.pg.gen};
    assign allProp = {treeIn.tree.prop, treeIn.pg.prop};

    // root level first; each odd-span group joins the prefix to its left,
    // which always sits on a higher level and is already done
    always_comb begin
        int span;
        int node;
        span      = 0;
        node      = 0;
        prefixGen = '0;
        for (int lvl = adderPkg::treeLevels; lvl >= 0; lvl--) begin
            span = 1 << lvl;
            for (int pos = span - 1; pos < width; pos += 2 * span) begin
                node = width + adderPkg::levelOffset(lvl) + pos / span;
                if (pos == span - 1) begin
                    prefixGen[pos] = allGen[node];
                end else begin
                    prefixGen[pos] = allGen[node] | (allProp[node] & prefixGen[pos - span]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= treeIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        aSignQ    <= treeIn.aSign;
        bSignQ    <= treeIn.bSign;
        propQ     <= treeIn.pg.prop;
        // carry into bit i is the prefix of bits below it
        carriesQ  <= {prefixGen[width-2:0], treeIn.carryIn};
        carryOutQ <= prefixGen[width-1];
    end

    assign carryOut = '{
        valid:    validQ,
        aSign:    aSignQ,
        bSign:    bSignQ,
        prop:     propQ,
        carries:  carriesQ,
        carryOut: carryOutQ
    };

endmodule

// File: source/prefixUpSweep.sv
module prefixUpSweep (
    input  logic             clk,
    input  logic             rstN,
    input  opPkg::pgPacket   pgIn,
    output opPkg::treePacket treeOut
);

    localparam int width = adderPkg::dataWidth;

    // group terms of all levels, filled in level by level
    wire adderPkg::sweepTree treeNext;
    adderPkg::pgVector       leafPg;

    logic               validQ;
    logic               aSignQ;
    logic               bSignQ;
    adderPkg::pgVector  pgQ;
    logic               carryQ;
    adderPkg::sweepTree treeQ;

    for (genvar lvl = 0; lvl <= adderPkg::treeLevels; lvl++) begin : gLevel
        logic [(width >> lvl)-1:0] gen;
        logic [(width >> lvl)-1:0] prop;

        if (lvl == 0) begin : gLeaf
            // carry-in folded into bit 0, so every group G is a full carry
            assign gen  = {pgIn.pg.gen[width-1:1],
                           pgIn.pg.gen[0] | (pgIn.pg.prop[0] & pgIn.carryIn)};
            assign prop = pgIn.pg.prop;
        end else begin : gPair
            for (genvar node = 0; node < (width >> lvl); node++) begin : gNode
                assign gen[node]  = gLevel[lvl-1].gen[2*node+1]
                                  | (gLevel[lvl-1].prop[2*node+1] & gLevel[lvl-1].gen[2*node]);
                assign prop[node] = gLevel[lvl-1].prop[2*node+1]
                                  & gLevel[lvl-1].prop[2*node];
            end

            assign treeNext.gen[adderPkg::levelOffset(lvl) +: (width >> lvl)]  = gen;
            assign treeNext.prop[adderPkg::levelOffset(lvl) +: (width >> lvl)] = prop;
        end
    end

    assign leafPg.gen  = gLevel[0].gen;
    assign leafPg.prop = gLevel[0].prop;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= pgIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        aSignQ <= pgIn.a[width-1];
        // conditioned b sign recovered from a and p
        bSignQ <= pgIn.a[width-1] ^ pgIn.pg.prop[width-1];
        pgQ    <= leafPg;
        carryQ <= pgIn.carryIn;
        treeQ  <= treeNext;
    end

    assign treeOut = '{
        valid:   validQ,
        aSign:   aSignQ,
        bSign:   bSignQ,
        pg:      pgQ,
        carryIn: carryQ,
        tree:    treeQ
    };

endmodule

// File: source/sumStage.sv
module sumStage (
    input  logic              clk,
    input  logic              rstN,
    input  opPkg::carryPacket carryIn,
    output logic              outValid,
    output opPkg::addResult   result
);

    localparam int width = adderPkg::dataWidth;

    adderPkg::dataWord sumNext;
    logic              overflowNext;

    assign sumNext = carryIn.prop ^ carryIn.carries;

    // same operand signs but a different result sign
    assign overflowNext = (carryIn.aSign == carryIn.bSign)
                        && (sumNext[width-1] != carryIn.aSign);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= carryIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        result.sum      <= sumNext;
        result.carryOut <= carryIn.carryOut;
        result.overflow <= overflowNext;
        result.zero     <= (sumNext == '0);
    end

endmodule

// File: sources.f
source/adderPkg.sv
source/opPkg.sv
source/operandStage.sv
source/prefixUpSweep.sv
source/prefixDownSweep.sv
source/sumStage.sv
source/prefixAdderTop.sv
verif/clockGen.sv
verif/prefixAdderTb.sv

// File: verif/clockGen.sv
module clockGen (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int resetCycles = 2;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: verif/prefixAdderTb.sv
module prefixAdderTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int width = adderPkg::dataWidth;
    localparam int latency = 4;
    localparam int numDirected = 12;
    localparam int numRandom = 2000;
    // each random request may bring one bubble along
    localparam int cycleLimit = numDirected + 2 * numRandom + 40;

    logic             clk;
    logic             rstN;
    logic             inValid;
    opPkg::addRequest request;
    logic             outValid;
    opPkg::addResult  result;

    opPkg::addResult    expectedQ[$];
    opPkg::addResult    headExpected;
    logic [latency-1:0] validPipe;
    int                 seed = 32'h37c1ab9a;
    int                 issuedCount = 0;
    int                 checkedCount = 0;
    int                 cycleCount = 0;

    clockGen clocks (
        .clk  (clk),
        .rstN (rstN)
    );

    prefixAdderTop DUT (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .request  (request),
        .outValid (outValid),
        .result   (result)
    );

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic reportMismatch(input string what);
        $display("error %0t: %s", $time, what);
        abortRun();
    endtask

    // reference sum of a, conditioned b and carry, 33 bits wide
    function automatic opPkg::addResult expectedFor(
        input opPkg::aluOp       op,
        input adderPkg::dataWord a,
        input adderPkg::dataWord b,
        input logic              carryIn
    );
        logic [width:0]    full;
        adderPkg::dataWord bEff;
        opPkg::addResult   r;
        case (op)
            opPkg::sub: begin
                // no borrow exactly when a >= b
                full = {a >= b, a - b};
                bEff = ~b;
            end
            opPkg::subWithBorrow: begin
                full = {1'b0, a} + {1'b0, ~b} + {{width{1'b0}}, carryIn};
                bEff = ~b;
            end
            default: begin
                full = {1'b0, a} + {1'b0, b} + {{width{1'b0}}, carryIn};
                bEff = b;
            end
        endcase
        r.sum      = full[width-1:0];
        r.carryOut = full[width];
        r.overflow = (a[width-1] == bEff[width-1]) && (full[width-1] != a[width-1]);
        r.zero     = (full[width-1:0] == '0);
        return r;
    endfunction

    function automatic opPkg::aluOp randomOp(input int pick);
        case (pick)
            0: return opPkg::add;
            1: return opPkg::sub;
            default: return opPkg::subWithBorrow;
        endcase
    endfunction

    // called on a falling edge, returns on the next one
    task automatic sendRequest(
        input opPkg::aluOp       op,
        input adderPkg::dataWord a,
        input adderPkg::dataWord b,
        input logic              carryIn
    );
        inValid = 1'b1;
        request = '{opcode: op, a: a, b: b, carryIn: carryIn};
        expectedQ.push_back(expectedFor(op, a, b, carryIn));
        issuedCount++;
        @(negedge clk);
    endtask

    task automatic sendBubble();
        inValid = 1'b0;
        // junk operands must not reach the output
        request.a = $random(seed);
        request.b = $random(seed);
        @(negedge clk);
    endtask

    // long carry chains and flag corners, back to back
    task automatic sendDirected();
        sendRequest(opPkg::add, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        sendRequest(opPkg::add, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
        sendRequest(opPkg::add, 32'hAAAA_AAAA, 32'h5555_5555, 1'b1);
        sendRequest(opPkg::add, 32'h5555_5555, 32'h5555_5555, 1'b0);
        sendRequest(opPkg::add, 32'h7FFF_FFFF, 32'h0000_0001, 1'b0);
        sendRequest(opPkg::add, 32'h8000_0000, 32'h8000_0000, 1'b0);
        sendRequest(opPkg::sub, 32'h1234_5678, 32'h1234_5678, 1'b0);
        sendRequest(opPkg::sub, 32'h0000_0000, 32'h0000_0001, 1'b1);
        sendRequest(opPkg::sub, 32'h8000_0000, 32'h0000_0001, 1'b0);
        sendRequest(opPkg::subWithBorrow, 32'h0000_0005, 32'h0000_0003, 1'b0);
        sendRequest(opPkg::subWithBorrow, 32'h0000_0005, 32'h0000_0003, 1'b1);
        sendRequest(opPkg::subWithBorrow, 32'h0000_0000, 32'h0000_0000, 1'b0);
    endtask

    task automatic sendRandomTraffic(input int count);
        adderPkg::dataWord a;
        adderPkg::dataWord b;
        logic [31:0]       roll;
        int                pick;
        for (int i = 0; i < count; i++) begin
            roll = $random(seed);
            if (roll[1:0] == 2'b00) begin
                sendBubble();
            end
            a = $random(seed);
            roll = $random(seed);
            // some a minus a for the zero flag
            if (roll[2:0] == 3'b000) begin
                b = a;
            end else begin
                b = $random(seed);
            end
            roll = $random(seed);
            pick = roll % 3;
            sendRequest(randomOp(pick), a, b, roll[8]);
        end
    endtask

    // model of the valid delay line
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[latency-2:0], inValid};
        end
    end

    // outputs hold between rising edges, so the next expected word is taken here
    always @(negedge clk) begin
        if (rstN && outValid) begin
            if (expectedQ.size() == 0) begin
                reportMismatch("a result appeared with no request outstanding");
            end else begin
                headExpected = expectedQ.pop_front();
                checkedCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("the run timed out after %0d cycles with %0d results still missing",
                     cycleLimit, expectedQ.size());
            abortRun();
        end
    end

    validCheck: assert property (@(posedge clk) disable iff (!rstN)
        outValid == validPipe[latency-1])
        else reportMismatch($sformatf("outValid %0b, expected %0b",
                                      $sampled(outValid), $sampled(validPipe[latency-1])));

    sumCheck: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> result.sum == headExpected.sum)
        else reportMismatch($sformatf("sum %h, expected %h",
                                      $sampled(result.sum), headExpected.sum));

    carryCheck: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> result.carryOut == headExpected.carryOut)
        else reportMismatch($sformatf("carryOut %0b, expected %0b for sum %h",
                                      $sampled(result.carryOut), headExpected.carryOut,
                                      headExpected.sum));

    overflowCheck: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> result.overflow == headExpected.overflow)
        else reportMismatch($sformatf("overflow %0b, expected %0b for sum %h",
                                      $sampled(result.overflow), headExpected.overflow,
                                      headExpected.sum));

    zeroCheck: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> result.zero == headExpected.zero)
        else reportMismatch($sformatf("zero %0b, expected %0b for sum %h",
                                      $sampled(result.zero), headExpected.zero,
                                      headExpected.sum));

    initial begin
        inValid      = 1'b0;
        request      = '0;
        headExpected = '0;
        wait (rstN === 1'b1);
        // pipeline must stay quiet after reset
        repeat (latency + 1) @(negedge clk);
        sendDirected();
        sendBubble();
        sendRandomTraffic(numRandom);
        inValid = 1'b0;
        wait (checkedCount == issuedCount);
        // let the last compare and a few idle outputs go by
        repeat (latency + 2) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule
